// ==== hw/hd_pkg.sv ====
`default_nettype none

package hd_pkg;

  // Configuration port widths
  localparam int unsigned CfgAddrWidth = 4;
  localparam int unsigned CfgDataWidth = 32;

  // Counter width used unless the top level overrides it
  localparam int unsigned DefaultCntWidth = 16;

  // Register map
  localparam logic [CfgAddrWidth-1:0] AddrReadHit   = 4'd0;
  localparam logic [CfgAddrWidth-1:0] AddrReadMiss  = 4'd1;
  localparam logic [CfgAddrWidth-1:0] AddrWriteHit  = 4'd2;
  localparam logic [CfgAddrWidth-1:0] AddrWriteMiss = 4'd3;
  localparam logic [CfgAddrWidth-1:0] AddrDmaEvt    = 4'd4;

  // Returned for any unmapped address
  localparam logic [CfgDataWidth-1:0] FillerData = 32'hdeadf000;

  // Write-data bits that select what gets cleared
  localparam int unsigned ClrLlcBit = 0;
  localparam int unsigned ClrDmaBit = 1;

  // Flops in the toggle synchroniser
  localparam int unsigned SyncStages = 2;

endpackage

`default_nettype wire

// ==== hw/llc_event_counters.sv ====
`default_nettype none

module llc_event_counters
  import hd_pkg::*;
#(
  parameter int unsigned CntWidth = DefaultCntWidth
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                rd_hit_i,
  input  logic                rd_miss_i,
  input  logic                wr_hit_i,
  input  logic                wr_miss_i,
  input  logic                clr_i,
  output logic [CntWidth-1:0] rd_hit_cnt_o,
  output logic [CntWidth-1:0] rd_miss_cnt_o,
  output logic [CntWidth-1:0] wr_hit_cnt_o,
  output logic [CntWidth-1:0] wr_miss_cnt_o
);

  localparam int unsigned NumEvents = 4;

  logic [NumEvents-1:0]               evt;
  logic [NumEvents-1:0][CntWidth-1:0] cnt_q;

  // Index order follows the register map
  assign evt = {wr_miss_i, wr_hit_i, rd_miss_i, rd_hit_i};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NumEvents; i++) begin
        // Clear has priority over a same-cycle event
        if (clr_i) begin
          cnt_q[i] <= '0;
        end else if (evt[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign rd_hit_cnt_o  = cnt_q[0];
  assign rd_miss_cnt_o = cnt_q[1];
  assign wr_hit_cnt_o  = cnt_q[2];
  assign wr_miss_cnt_o = cnt_q[3];

endmodule

`default_nettype wire

// ==== hw/dma_evt_rx.sv ====
`default_nettype none

module dma_evt_rx
  import hd_pkg::*;
#(
  parameter int unsigned CntWidth = DefaultCntWidth
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                valid_i,
  input  logic                clr_i,
  output logic                ack_o,
  output logic [CntWidth-1:0] evt_cnt_o
);

  logic [SyncStages-1:0] sync_q;
  logic                  level_q;
  logic                  evt_pulse;
  logic [CntWidth-1:0]   cnt_q;

  // Toggle arrives from the cluster clock domain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[SyncStages-2:0], valid_i};
      level_q <= sync_q[SyncStages-1];
    end
  end

  // Any change of the synchronised level is one event
  assign evt_pulse = sync_q[SyncStages-1] ^ level_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (evt_pulse) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Ack flips back to the sender on the same edge the count moves
  assign ack_o     = level_q;
  assign evt_cnt_o = cnt_q;

endmodule

`default_nettype wire

// ==== hw/cfg_responder.sv ====
`default_nettype none

module cfg_responder
  import hd_pkg::*;
#(
  parameter int unsigned CntWidth = DefaultCntWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Read request and response
  input  logic                    ar_valid_i,
  input  logic [CfgAddrWidth-1:0] ar_addr_i,
  input  logic                    r_ready_i,
  output logic                    r_valid_o,
  output logic [CfgDataWidth-1:0] r_data_o,
  // Write request and response
  input  logic                    w_valid_i,
  input  logic [CfgDataWidth-1:0] w_data_i,
  input  logic                    b_ready_i,
  output logic                    b_valid_o,
  // Counter values
  input  logic [CntWidth-1:0]     rd_hit_cnt_i,
  input  logic [CntWidth-1:0]     rd_miss_cnt_i,
  input  logic [CntWidth-1:0]     wr_hit_cnt_i,
  input  logic [CntWidth-1:0]     wr_miss_cnt_i,
  input  logic [CntWidth-1:0]     dma_cnt_i,
  // Clear strobes
  output logic                    llc_clr_o,
  output logic                    dma_clr_o
);

  logic                    r_valid_q;
  logic                    b_valid_q;
  logic [CfgDataWidth-1:0] r_data_q;
  logic [CfgDataWidth-1:0] rd_sel;
  logic                    rd_accept;
  logic                    wr_accept;

  // New requests only when the previous response is gone
  assign rd_accept = ar_valid_i & ~r_valid_q;
  assign wr_accept = w_valid_i & ~b_valid_q;

  always_comb begin
    case (ar_addr_i)
      AddrReadHit:   rd_sel = CfgDataWidth'(rd_hit_cnt_i);
      AddrReadMiss:  rd_sel = CfgDataWidth'(rd_miss_cnt_i);
      AddrWriteHit:  rd_sel = CfgDataWidth'(wr_hit_cnt_i);
      AddrWriteMiss: rd_sel = CfgDataWidth'(wr_miss_cnt_i);
      AddrDmaEvt:    rd_sel = CfgDataWidth'(dma_cnt_i);
      default:       rd_sel = FillerData;
    endcase
  end

  // Read valid held until ready
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_accept) begin
      r_valid_q <= 1'b1;
    end else if (r_valid_q && r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= rd_sel;
    end
  end

  // Write response held until ready
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (b_valid_q && b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  // Counters clear at the accepting edge itself
  assign llc_clr_o = wr_accept & w_data_i[ClrLlcBit];
  assign dma_clr_o = wr_accept & w_data_i[ClrDmaBit];

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign b_valid_o = b_valid_q;

endmodule

`default_nettype wire

// ==== hw/host_domain.sv ====
`default_nettype none

module host_domain
  import hd_pkg::*;
#(
  parameter int unsigned CntWidth = DefaultCntWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Cache events
  input  logic                    llc_rd_hit_i,
  input  logic                    llc_rd_miss_i,
  input  logic                    llc_wr_hit_i,
  input  logic                    llc_wr_miss_i,
  // Cluster DMA event toggle
  input  logic                    dma_evt_valid_i,
  output logic                    dma_evt_ack_o,
  // Configuration port
  input  logic                    cfg_ar_valid_i,
  input  logic [CfgAddrWidth-1:0] cfg_ar_addr_i,
  input  logic                    cfg_r_ready_i,
  output logic                    cfg_r_valid_o,
  output logic [CfgDataWidth-1:0] cfg_r_data_o,
  input  logic                    cfg_w_valid_i,
  input  logic [CfgAddrWidth-1:0] cfg_w_addr_i,
  input  logic [CfgDataWidth-1:0] cfg_w_data_i,
  input  logic                    cfg_b_ready_i,
  output logic                    cfg_b_valid_o
);

  logic [CntWidth-1:0] rd_hit_cnt;
  logic [CntWidth-1:0] rd_miss_cnt;
  logic [CntWidth-1:0] wr_hit_cnt;
  logic [CntWidth-1:0] wr_miss_cnt;
  logic [CntWidth-1:0] dma_cnt;
  logic                llc_clr;
  logic                dma_clr;

  llc_event_counters #(
    .CntWidth ( CntWidth )
  ) i_llc_event_counters (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .rd_hit_i      ( llc_rd_hit_i  ),
    .rd_miss_i     ( llc_rd_miss_i ),
    .wr_hit_i      ( llc_wr_hit_i  ),
    .wr_miss_i     ( llc_wr_miss_i ),
    .clr_i         ( llc_clr       ),
    .rd_hit_cnt_o  ( rd_hit_cnt    ),
    .rd_miss_cnt_o ( rd_miss_cnt   ),
    .wr_hit_cnt_o  ( wr_hit_cnt    ),
    .wr_miss_cnt_o ( wr_miss_cnt   )
  );

  dma_evt_rx #(
    .CntWidth ( CntWidth )
  ) i_dma_evt_rx (
    .clk_i     ( clk_i           ),
    .rst_i     ( rst_i           ),
    .valid_i   ( dma_evt_valid_i ),
    .clr_i     ( dma_clr         ),
    .ack_o     ( dma_evt_ack_o   ),
    .evt_cnt_o ( dma_cnt         )
  );

  // Write address is taken but clears are chosen by the data bits
  cfg_responder #(
    .CntWidth ( CntWidth )
  ) i_cfg_responder (
    .clk_i         ( clk_i          ),
    .rst_i         ( rst_i          ),
    .ar_valid_i    ( cfg_ar_valid_i ),
    .ar_addr_i     ( cfg_ar_addr_i  ),
    .r_ready_i     ( cfg_r_ready_i  ),
    .r_valid_o     ( cfg_r_valid_o  ),
    .r_data_o      ( cfg_r_data_o   ),
    .w_valid_i     ( cfg_w_valid_i  ),
    .w_data_i      ( cfg_w_data_i   ),
    .b_ready_i     ( cfg_b_ready_i  ),
    .b_valid_o     ( cfg_b_valid_o  ),
    .rd_hit_cnt_i  ( rd_hit_cnt     ),
    .rd_miss_cnt_i ( rd_miss_cnt    ),
    .wr_hit_cnt_i  ( wr_hit_cnt     ),
    .wr_miss_cnt_i ( wr_miss_cnt    ),
    .dma_cnt_i     ( dma_cnt        ),
    .llc_clr_o     ( llc_clr        ),
    .dma_clr_o     ( dma_clr        )
  );

endmodule

`default_nettype wire

// ==== sim/hd_checker.sv ====
`default_nettype none

module hd_checker
  import hd_pkg::*;
#(
  parameter int unsigned CntWidth = DefaultCntWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    llc_rd_hit_i,
  input  logic                    llc_rd_miss_i,
  input  logic                    llc_wr_hit_i,
  input  logic                    llc_wr_miss_i,
  input  logic                    dma_evt_valid_i,
  input  logic                    dma_evt_ack_i,
  input  logic                    cfg_ar_valid_i,
  input  logic [CfgAddrWidth-1:0] cfg_ar_addr_i,
  input  logic                    cfg_r_ready_i,
  input  logic                    cfg_r_valid_i,
  input  logic [CfgDataWidth-1:0] cfg_r_data_i,
  input  logic                    cfg_w_valid_i,
  input  logic [CfgDataWidth-1:0] cfg_w_data_i,
  input  logic                    cfg_b_ready_i,
  input  logic                    cfg_b_valid_i,
  output int                      data_err_o,
  output int                      proto_err_o,
  output int                      reads_checked_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [63:0]             cnt_mask;
  logic [63:0]             llc_cnt [4];
  logic [63:0]             dma_cnt;
  // Toggle as seen after three edges
  logic [2:0]              dma_dly;
  logic [3:0]              evt;
  logic [CfgDataWidth-1:0] exp_rd_data;
  logic                    rd_acc;
  logic                    wr_acc;
  logic                    rd_due;
  logic                    b_due;
  logic                    rd_held;
  logic                    b_held;
  logic                    rd_bad;

  assign cnt_mask = (64'd1 << CntWidth) - 64'd1;
  assign evt      = {llc_wr_miss_i, llc_wr_hit_i, llc_rd_miss_i, llc_rd_hit_i};

  function automatic logic [CfgDataWidth-1:0] expected_read(input logic [CfgAddrWidth-1:0] a);
    case (a)
      AddrReadHit:   return CfgDataWidth'(llc_cnt[0]);
      AddrReadMiss:  return CfgDataWidth'(llc_cnt[1]);
      AddrWriteHit:  return CfgDataWidth'(llc_cnt[2]);
      AddrWriteMiss: return CfgDataWidth'(llc_cnt[3]);
      AddrDmaEvt:    return CfgDataWidth'(dma_cnt);
      default:       return FillerData;
    endcase
  endfunction

  initial begin
    data_err_o      = 0;
    proto_err_o     = 0;
    reads_checked_o = 0;
  end

  // All values are taken as they stood just before the edge
  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 4; i++) llc_cnt[i] = '0;
      dma_cnt = '0;
      dma_dly = '0;
      rd_due  = 1'b0;
      b_due   = 1'b0;
      rd_held = 1'b0;
      b_held  = 1'b0;
      rd_bad  = 1'b0;
    end else begin
      if (rd_due && !cfg_r_valid_i) begin
        proto_err_o++;
        $display("A read was accepted but no read response followed one cycle later");
      end
      if (rd_held && !cfg_r_valid_i) begin
        proto_err_o++;
        $display("The read response was withdrawn before r_ready");
      end
      if (cfg_r_valid_i && !rd_due && !rd_held) begin
        proto_err_o++;
        $display("A read response appeared without an accepted read");
      end
      if (b_due && !cfg_b_valid_i) begin
        proto_err_o++;
        $display("A write was accepted but no write response followed one cycle later");
      end
      if (b_held && !cfg_b_valid_i) begin
        proto_err_o++;
        $display("The write response was withdrawn before b_ready");
      end
      if (cfg_b_valid_i && !b_due && !b_held) begin
        proto_err_o++;
        $display("A write response appeared without an accepted write");
      end

      // Data must also stay steady while stalled
      if (cfg_r_valid_i) begin
        if (cfg_r_data_i !== exp_rd_data && !rd_bad) begin
          data_err_o++;
          $display("Error at %0t: read data %h, expected %h", $time, cfg_r_data_i, exp_rd_data);
          rd_bad = 1'b1;
        end
        if (cfg_r_ready_i) begin
          reads_checked_o++;
          rd_bad = 1'b0;
        end
      end

      if (dma_evt_ack_i !== dma_dly[2]) begin
        data_err_o++;
        $display("Error at %0t: DMA ack %b, expected %b", $time, dma_evt_ack_i, dma_dly[2]);
      end

      rd_acc = cfg_ar_valid_i && !cfg_r_valid_i;
      wr_acc = cfg_w_valid_i && !cfg_b_valid_i;
      if (rd_acc) exp_rd_data = expected_read(cfg_ar_addr_i);
      rd_due  = rd_acc;
      b_due   = wr_acc;
      rd_held = cfg_r_valid_i && !cfg_r_ready_i;
      b_held  = cfg_b_valid_i && !cfg_b_ready_i;

      // Clear wins over an event at the same edge
      for (int i = 0; i < 4; i++) begin
        if (wr_acc && cfg_w_data_i[ClrLlcBit]) llc_cnt[i] = '0;
        else if (evt[i]) llc_cnt[i] = (llc_cnt[i] + 64'd1) & cnt_mask;
      end
      if (wr_acc && cfg_w_data_i[ClrDmaBit]) dma_cnt = '0;
      else if (dma_dly[2] != dma_dly[1]) dma_cnt = (dma_cnt + 64'd1) & cnt_mask;
      dma_dly = {dma_dly[1:0], dma_evt_valid_i};
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_host_domain.sv ====
`default_nettype none

module tb_host_domain
  import hd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Narrow counters so that wrap shows up in short bursts
  localparam int unsigned CntWidth = 4;

  logic                    clk;
  logic                    rst;
  logic                    llc_rd_hit;
  logic                    llc_rd_miss;
  logic                    llc_wr_hit;
  logic                    llc_wr_miss;
  logic                    dma_evt_valid;
  logic                    dma_evt_ack;
  logic                    cfg_ar_valid;
  logic [CfgAddrWidth-1:0] cfg_ar_addr;
  logic                    cfg_r_ready;
  logic                    cfg_r_valid;
  logic [CfgDataWidth-1:0] cfg_r_data;
  logic                    cfg_w_valid;
  logic [CfgAddrWidth-1:0] cfg_w_addr;
  logic [CfgDataWidth-1:0] cfg_w_data;
  logic                    cfg_b_ready;
  logic                    cfg_b_valid;

  int data_err;
  int proto_err;
  int reads_checked;
  int reads_issued;
  int run_err;
  int cycle_cnt;
  int cycle_limit;
  integer seed;

  logic [63:0] cmd_q [$];
  logic [31:0] a_q [$];
  logic [31:0] b_q [$];

  host_domain #(
    .CntWidth ( CntWidth )
  ) dut_i (
    .clk_i           ( clk           ),
    .rst_i           ( rst           ),
    .llc_rd_hit_i    ( llc_rd_hit    ),
    .llc_rd_miss_i   ( llc_rd_miss   ),
    .llc_wr_hit_i    ( llc_wr_hit    ),
    .llc_wr_miss_i   ( llc_wr_miss   ),
    .dma_evt_valid_i ( dma_evt_valid ),
    .dma_evt_ack_o   ( dma_evt_ack   ),
    .cfg_ar_valid_i  ( cfg_ar_valid  ),
    .cfg_ar_addr_i   ( cfg_ar_addr   ),
    .cfg_r_ready_i   ( cfg_r_ready   ),
    .cfg_r_valid_o   ( cfg_r_valid   ),
    .cfg_r_data_o    ( cfg_r_data    ),
    .cfg_w_valid_i   ( cfg_w_valid   ),
    .cfg_w_addr_i    ( cfg_w_addr    ),
    .cfg_w_data_i    ( cfg_w_data    ),
    .cfg_b_ready_i   ( cfg_b_ready   ),
    .cfg_b_valid_o   ( cfg_b_valid   )
  );

  hd_checker #(
    .CntWidth ( CntWidth )
  ) i_hd_checker (
    .clk_i           ( clk           ),
    .rst_i           ( rst           ),
    .llc_rd_hit_i    ( llc_rd_hit    ),
    .llc_rd_miss_i   ( llc_rd_miss   ),
    .llc_wr_hit_i    ( llc_wr_hit    ),
    .llc_wr_miss_i   ( llc_wr_miss   ),
    .dma_evt_valid_i ( dma_evt_valid ),
    .dma_evt_ack_i   ( dma_evt_ack   ),
    .cfg_ar_valid_i  ( cfg_ar_valid  ),
    .cfg_ar_addr_i   ( cfg_ar_addr   ),
    .cfg_r_ready_i   ( cfg_r_ready   ),
    .cfg_r_valid_i   ( cfg_r_valid   ),
    .cfg_r_data_i    ( cfg_r_data    ),
    .cfg_w_valid_i   ( cfg_w_valid   ),
    .cfg_w_data_i    ( cfg_w_data    ),
    .cfg_b_ready_i   ( cfg_b_ready   ),
    .cfg_b_valid_i   ( cfg_b_valid   ),
    .data_err_o      ( data_err      ),
    .proto_err_o     ( proto_err     ),
    .reads_checked_o ( reads_checked )
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_events(input logic [3:0] mask);
    {llc_wr_miss, llc_wr_hit, llc_rd_miss, llc_rd_hit} = mask;
  endtask

  task automatic report_counts();
    $display("Errors: data %0d, protocol %0d, testbench %0d", data_err, proto_err, run_err);
  endtask

  task automatic load_cases();
    integer      fd;
    integer      n;
    logic [63:0] cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [8*120-1:0] line;
    bit          done;
    done = 0;
    fd = $fopen("sim/host_domain_cases.txt", "r");
    if (fd == 0) begin
      run_err++;
      $display("Could not open the cases file sim/host_domain_cases.txt");
      done = 1;
    end
    while (!done) begin
      n = $fscanf(fd, "%s", cmd);
      if (n != 1) begin
        done = 1;
      end else if (cmd == "#") begin
        n = $fgets(line, fd);
      end else begin
        a = '0;
        b = '0;
        if (cmd == "burst" || cmd == "read" || cmd == "write") begin
          n = $fscanf(fd, "%h %h", a, b);
        end else if (cmd == "rburst") begin
          n = $fscanf(fd, "%h", a);
        end
        cmd_q.push_back(cmd);
        a_q.push_back(a);
        b_q.push_back(b);
        // Budget grows with every command and with the burst lengths
        cycle_limit += 20;
        if (cmd == "burst") cycle_limit += b;
        if (cmd == "rburst") cycle_limit += a;
        if (cmd == "end") done = 1;
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  task automatic run_burst(input logic [3:0] mask, input int cycles);
    repeat (cycles) begin
      set_events(mask);
      next_cycle();
    end
    set_events(4'h0);
  endtask

  task automatic run_random_burst(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = $random(seed);
      set_events(r[3:0]);
      next_cycle();
    end
    set_events(4'h0);
  endtask

  task automatic toggle_dma();
    dma_evt_valid = ~dma_evt_valid;
    repeat (5) next_cycle();
  endtask

  task automatic do_read(input logic [CfgAddrWidth-1:0] addr, input int stall);
    int waited;
    waited = 0;
    cfg_ar_valid = 1'b1;
    cfg_ar_addr  = addr;
    next_cycle();
    // Extra requests with a differently answered address while stalled must be ignored
    cfg_ar_addr  = (addr > AddrDmaEvt) ? AddrReadMiss : 4'hf;
    cfg_ar_valid = (stall > 0);
    while (!cfg_r_valid && waited < 4) begin
      next_cycle();
      waited++;
    end
    if (!cfg_r_valid) begin
      run_err++;
      $display("No read response for a read of address %0d", addr);
      cfg_ar_valid = 1'b0;
      return;
    end
    repeat (stall) next_cycle();
    cfg_r_ready = 1'b1;
    next_cycle();
    cfg_r_ready  = 1'b0;
    cfg_ar_valid = 1'b0;
    reads_issued++;
  endtask

  task automatic do_write(input logic [31:0] clr, input logic [3:0] mask);
    int waited;
    waited = 0;
    cfg_w_valid = 1'b1;
    cfg_w_data  = clr;
    cfg_w_addr  = clr[3:0];
    set_events(mask);
    next_cycle();
    cfg_w_valid = 1'b0;
    set_events(4'h0);
    while (!cfg_b_valid && waited < 4) begin
      next_cycle();
      waited++;
    end
    if (!cfg_b_valid) begin
      run_err++;
      $display("No write response after a write with clear bits %h", clr);
      return;
    end
    repeat (2) next_cycle();
    cfg_b_ready = 1'b1;
    next_cycle();
    cfg_b_ready = 1'b0;
  endtask

  task automatic run_cases();
    for (int k = 0; k < cmd_q.size(); k++) begin
      case (cmd_q[k])
        "burst":  run_burst(a_q[k][3:0], b_q[k]);
        "rburst": run_random_burst(a_q[k]);
        "dma":    toggle_dma();
        "read":   do_read(a_q[k][CfgAddrWidth-1:0], b_q[k]);
        "write":  do_write(a_q[k], b_q[k][3:0]);
        "end":    ;
        default: begin
          run_err++;
          $display("Unknown command in the cases file at entry %0d", k);
        end
      endcase
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run hung and was stopped after %0d cycles", cycle_cnt);
      report_counts();
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    seed          = 2347;
    cycle_cnt     = 0;
    cycle_limit   = 100;
    run_err       = 0;
    reads_issued  = 0;
    rst           = 1'b1;
    set_events(4'h0);
    dma_evt_valid = 1'b0;
    cfg_ar_valid  = 1'b0;
    cfg_ar_addr   = '0;
    cfg_r_ready   = 1'b0;
    cfg_w_valid   = 1'b0;
    cfg_w_addr    = '0;
    cfg_w_data    = '0;
    cfg_b_ready   = 1'b0;
    load_cases();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    run_cases();
    repeat (4) next_cycle();
    if (reads_checked != reads_issued) begin
      run_err++;
      $display("Checker saw %0d read responses but %0d reads were issued",
               reads_checked, reads_issued);
    end
    report_counts();
    if (data_err + proto_err + run_err == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/host_domain_cases.txt ====
# Columns: command, then its operands in hex
# burst <mask> <cycles> | rburst <cycles> | dma | read <addr> <stall> | write <clr> <evt_mask> | end
read 0 0
read 1 0
read 2 0
read 3 0
read 4 2
burst 1 3
burst 6 5
burst f 14
read 0 0
read 1 3
read 2 0
read 3 0
dma
dma
dma
read 4 0
read 9 4
rburst 28
read 0 1
read 3 0
write 1 f
read 1 0
read 4 0
dma
write 2 5
read 0 0
read 4 0
read f 2
end

// ==== list.f ====
hw/hd_pkg.sv
hw/llc_event_counters.sv
hw/dma_evt_rx.sv
hw/cfg_responder.sv
hw/host_domain.sv
sim/hd_checker.sv
sim/tb_host_domain.sv
